/* io_proto_pkg.sv */
`default_nettype none

package io_proto_pkg;

	// command opcodes sent by the io controller as the first byte
	typedef enum logic [7:0] {
		cmd_but_sw     = 8'h01,
		cmd_ikbd_in    = 8'h02,
		cmd_ikbd_out   = 8'h03,
		cmd_ser_in     = 8'h04,
		cmd_ser_out    = 8'h05,
		cmd_par_out    = 8'h06,
		cmd_midi_out   = 8'h08,
		cmd_eth_mac    = 8'h09,
		cmd_eth_status = 8'h0A,
		cmd_eth_tx_rd  = 8'h0B,
		cmd_eth_rx_wr  = 8'h0C,
		cmd_ser_status = 8'h0D,
		cmd_joy0       = 8'h10,
		cmd_joy1       = 8'h11,
		cmd_joy2       = 8'h12,
		cmd_joy3       = 8'h13
	} io_cmd_e;

	// length of the command phase in bits
	localparam int cmd_bits = 8;

	// bit counter runs 0..7 once, then 8..15 for every payload byte
	localparam logic [3:0] payload_start = 4'd8;
	localparam logic [3:0] last_bit = 4'd15;

	// strobes toward the core drop when this bit of the next byte ends
	localparam logic [3:0] strobe_clr_bit = 4'd9;

	// lets the controller tell a core that lacks serial status support
	localparam logic [7:0] status_marker = 8'hA5;

endpackage

`default_nettype wire

/* io_core_pkg.sv */
`default_nettype none

package io_core_pkg;

	// byte handed to the core, data valid while strobe is high
	typedef struct packed {
		logic       strobe;
		logic [7:0] data;
	} byte_in_t;

	// byte the core offers for polling
	typedef struct packed {
		logic       avail;
		logic [7:0] data;
	} byte_out_t;

	// ethernet byte stream, start marks a new transfer
	typedef struct packed {
		logic       start;
		logic       strobe;
		logic [7:0] data;
	} eth_stream_t;

	// one joystick, bit order as sent by the controller
	typedef struct packed {
		logic fire2;
		logic fire1;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

	// on-board buttons and dip switches
	typedef struct packed {
		logic       scandoubler_disable;
		logic [1:0] switches;
		logic [1:0] buttons;
	} ctrl_t;

endpackage

`default_nettype wire

/* spi_frame.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_frame (
	input  logic                  spi_sck,
	input  logic                  SPI_SS_IO,
	input  logic                  mosi,
	output logic [3:0]            bit_cnt,
	output logic [3:0]            byte_cnt,
	output io_proto_pkg::io_cmd_e cmd,
	output logic [7:0]            rx_byte,
	output logic                  byte_done
);

	import io_proto_pkg::*;

	// last seven bits received, oldest in the msb
	logic [6:0] sbuf;

	// a byte is complete when the current mosi bit is its eighth
	assign rx_byte = {sbuf, mosi};
	assign byte_done = (bit_cnt[2:0] == 3'd7);

	always_ff @(posedge spi_sck) begin
		sbuf <= {sbuf[5:0], mosi};
	end

	// position within the transaction
	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt <= 4'd0;
			byte_cnt <= 4'd0;
		end else begin
			if (bit_cnt != last_bit) begin
				bit_cnt <= bit_cnt + 4'd1;
			end else begin
				// back to the start of the next payload byte
				bit_cnt <= payload_start;
				byte_cnt <= byte_cnt + 4'd1;
			end
		end
	end

	// opcode is taken from the first byte only
	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			cmd <= io_cmd_e'(8'h00);
		end else if (bit_cnt == 4'(cmd_bits - 1)) begin
			cmd <= io_cmd_e'(rx_byte);
		end
	end

endmodule

`default_nettype wire

/* user_io_cmd.sv */
`timescale 1ns/1ps
`default_nettype none

module user_io_cmd #(
	parameter int num_joy = 4
) (
	input  logic                     spi_sck,
	input  logic                     SPI_SS_IO,
	input  logic [3:0]               bit_cnt,
	input  logic [3:0]               byte_cnt,
	input  io_proto_pkg::io_cmd_e    cmd,
	input  logic [7:0]               rx_byte,
	input  logic                     byte_done,
	output io_core_pkg::ctrl_t       ctrl,
	output io_core_pkg::joy_t        joy [num_joy],
	output io_core_pkg::byte_in_t    ikbd_in,
	output io_core_pkg::byte_in_t    ser_in,
	output logic [7:0]               ser_status_in,
	output logic                     ikbd_rd,
	output logic                     ser_rd,
	output logic                     par_rd,
	output logic                     midi_rd,
	output io_core_pkg::eth_stream_t eth_mac,
	output io_core_pkg::eth_stream_t eth_rx,
	output logic                     eth_tx_begin,
	output logic                     eth_tx_strobe
);

	import io_proto_pkg::*;
	import io_core_pkg::*;

	logic cmd_done;
	logic pay_done;

	// strobe flops
	logic ikbd_stb;
	logic ser_stb;
	logic mac_start;
	logic mac_stb;
	logic rx_start;
	logic rx_stb;

	// data flops, these survive the end of a transaction
	logic [7:0] ikbd_q;
	logic [7:0] ser_q;
	logic [7:0] mac_q;
	logic [7:0] rx_q;

	// bit_cnt bit 3 tells the payload from the command byte
	assign cmd_done = byte_done && !bit_cnt[3];
	assign pay_done = byte_done && bit_cnt[3];

	assign ikbd_in = '{strobe: ikbd_stb, data: ikbd_q};
	assign ser_in = '{strobe: ser_stb, data: ser_q};
	assign eth_mac = '{start: mac_start, strobe: mac_stb, data: mac_q};
	assign eth_rx = '{start: rx_start, strobe: rx_stb, data: rx_q};

	// payload capture
	always_ff @(posedge spi_sck) begin
		if (pay_done) begin
			case (cmd)
				cmd_but_sw:    ctrl <= rx_byte[4:0];
				cmd_ikbd_in:   ikbd_q <= rx_byte;
				cmd_ser_in:    ser_q <= rx_byte;
				cmd_eth_mac:   mac_q <= rx_byte;
				cmd_eth_rx_wr: rx_q <= rx_byte;
				cmd_ser_status: begin
					// byte 0 is the marker slot, status follows in byte 1
					if (byte_cnt == 4'd1) begin
						ser_status_in <= rx_byte;
					end
				end
				default: ;
			endcase
			for (int i = 0; i < num_joy; i++) begin
				if (8'(cmd) == 8'(cmd_joy0) + 8'(i)) begin
					joy[i] <= rx_byte[5:0];
				end
			end
		end
	end

	// strobes and begin flags toward the core
	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			ikbd_stb <= 1'b0;
			ser_stb <= 1'b0;
			ikbd_rd <= 1'b0;
			ser_rd <= 1'b0;
			par_rd <= 1'b0;
			midi_rd <= 1'b0;
			mac_start <= 1'b0;
			mac_stb <= 1'b0;
			rx_start <= 1'b0;
			rx_stb <= 1'b0;
			eth_tx_begin <= 1'b0;
			eth_tx_strobe <= 1'b0;
		end else begin
			if (bit_cnt == strobe_clr_bit) begin
				ikbd_stb <= 1'b0;
				ser_stb <= 1'b0;
				ikbd_rd <= 1'b0;
				ser_rd <= 1'b0;
				par_rd <= 1'b0;
				midi_rd <= 1'b0;
				mac_stb <= 1'b0;
				rx_stb <= 1'b0;
				eth_tx_strobe <= 1'b0;
			end
			// ethernet transfers announce themselves right after the opcode
			if (cmd_done) begin
				if (rx_byte == cmd_eth_mac) begin
					mac_start <= 1'b1;
				end
				if (rx_byte == cmd_eth_tx_rd) begin
					eth_tx_begin <= 1'b1;
					eth_tx_strobe <= 1'b1;
				end
				if (rx_byte == cmd_eth_rx_wr) begin
					rx_start <= 1'b1;
				end
			end
			if (pay_done) begin
				// mac begin only covers the first address byte
				mac_start <= 1'b0;
				case (cmd)
					cmd_ikbd_in:   ikbd_stb <= 1'b1;
					cmd_ser_in:    ser_stb <= 1'b1;
					// read channels advance once the data byte went out
					cmd_ikbd_out:  ikbd_rd <= byte_cnt[0];
					cmd_ser_out:   ser_rd <= byte_cnt[0];
					cmd_par_out:   par_rd <= byte_cnt[0];
					cmd_midi_out:  midi_rd <= byte_cnt[0];
					cmd_eth_mac:   mac_stb <= 1'b1;
					cmd_eth_tx_rd: eth_tx_strobe <= 1'b1;
					cmd_eth_rx_wr: rx_stb <= 1'b1;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* user_io_reply.sv */
`timescale 1ns/1ps
`default_nettype none

module user_io_reply #(
	parameter logic [7:0] core_type = 8'h00
) (
	input  logic                   spi_sck,
	input  logic [3:0]             bit_cnt,
	input  logic [3:0]             byte_cnt,
	input  io_proto_pkg::io_cmd_e  cmd,
	input  io_core_pkg::byte_out_t ikbd_out,
	input  io_core_pkg::byte_out_t ser_out,
	input  io_core_pkg::byte_out_t par_out,
	input  io_core_pkg::byte_out_t midi_out,
	input  logic [31:0]            eth_status,
	input  logic [7:0]             eth_tx_byte,
	input  logic [63:0]            ser_status_out,
	output logic                   miso
);

	import io_proto_pkg::*;
	import io_core_pkg::*;

	logic [2:0]  tx_bit;
	logic [4:0]  eth_idx;
	logic [6:0]  ser_idx;
	logic [71:0] ser_status_x;
	logic        next_bit;

	// msb first within every byte
	assign tx_bit = ~bit_cnt[2:0];

	// status word goes out msb byte first
	assign eth_idx = {~byte_cnt[1:0], tx_bit};

	// marker goes out in byte 0 and the status bytes 1..8 follow msb first
	assign ser_status_x = {status_marker, ser_status_out};
	assign ser_idx = {4'd8 - byte_cnt, tx_bit};

	// available flag in even bytes, data in odd bytes
	function automatic logic chan_bit(input byte_out_t ch, input logic odd,
			input logic [2:0] idx);
		logic res;
		res = odd ? ch.data[idx] : ch.avail;
		return res;
	endfunction

	always_comb begin
		next_bit = 1'b0;
		if (!bit_cnt[3]) begin
			next_bit = core_type[tx_bit];
		end else begin
			case (cmd)
				cmd_ikbd_out:   next_bit = chan_bit(ikbd_out, byte_cnt[0], tx_bit);
				cmd_ser_out:    next_bit = chan_bit(ser_out, byte_cnt[0], tx_bit);
				cmd_par_out:    next_bit = chan_bit(par_out, byte_cnt[0], tx_bit);
				cmd_midi_out:   next_bit = chan_bit(midi_out, byte_cnt[0], tx_bit);
				cmd_eth_status: next_bit = eth_status[eth_idx];
				cmd_eth_tx_rd:  next_bit = eth_tx_byte[tx_bit];
				cmd_ser_status: begin
					// nothing left to send past the last status byte
					if (byte_cnt <= 4'd8) begin
						next_bit = ser_status_x[ser_idx];
					end
				end
				default:        next_bit = 1'b0;
			endcase
		end
	end

	// master samples on the rising edge, so change on the falling one
	always_ff @(negedge spi_sck) begin
		miso <= next_bit;
	end

endmodule

`default_nettype wire

/* user_io.sv */
`timescale 1ns/1ps
`default_nettype none

module user_io #(
	parameter logic [7:0] core_type = 8'h00,
	parameter int         num_joy = 4
) (
	input  logic                     spi_sck,
	input  logic                     SPI_SS_IO,
	input  logic                     mosi,
	output logic                     miso,
	// controller to core
	output io_core_pkg::ctrl_t       ctrl,
	output io_core_pkg::joy_t        joy [num_joy],
	output io_core_pkg::byte_in_t    ikbd_in,
	output io_core_pkg::byte_in_t    ser_in,
	output logic [7:0]               ser_status_in,
	output io_core_pkg::eth_stream_t eth_mac,
	output io_core_pkg::eth_stream_t eth_rx,
	// core to controller
	input  io_core_pkg::byte_out_t   ikbd_out,
	input  io_core_pkg::byte_out_t   ser_out,
	input  io_core_pkg::byte_out_t   par_out,
	input  io_core_pkg::byte_out_t   midi_out,
	output logic                     ikbd_rd,
	output logic                     ser_rd,
	output logic                     par_rd,
	output logic                     midi_rd,
	input  logic [31:0]              eth_status,
	input  logic [7:0]               eth_tx_byte,
	output logic                     eth_tx_begin,
	output logic                     eth_tx_strobe,
	input  logic [63:0]              ser_status_out
);

	import io_proto_pkg::*;

	logic [3:0] bit_cnt;
	logic [3:0] byte_cnt;
	io_cmd_e    cmd;
	logic [7:0] rx_byte;
	logic       byte_done;

	spi_frame u_frame (
		.spi_sck  (spi_sck),
		.SPI_SS_IO(SPI_SS_IO),
		.mosi     (mosi),
		.bit_cnt  (bit_cnt),
		.byte_cnt (byte_cnt),
		.cmd      (cmd),
		.rx_byte  (rx_byte),
		.byte_done(byte_done)
	);

	user_io_cmd #(
		.num_joy(num_joy)
	) u_cmd (
		.spi_sck      (spi_sck),
		.SPI_SS_IO    (SPI_SS_IO),
		.bit_cnt      (bit_cnt),
		.byte_cnt     (byte_cnt),
		.cmd          (cmd),
		.rx_byte      (rx_byte),
		.byte_done    (byte_done),
		.ctrl         (ctrl),
		.joy          (joy),
		.ikbd_in      (ikbd_in),
		.ser_in       (ser_in),
		.ser_status_in(ser_status_in),
		.ikbd_rd      (ikbd_rd),
		.ser_rd       (ser_rd),
		.par_rd       (par_rd),
		.midi_rd      (midi_rd),
		.eth_mac      (eth_mac),
		.eth_rx       (eth_rx),
		.eth_tx_begin (eth_tx_begin),
		.eth_tx_strobe(eth_tx_strobe)
	);

	user_io_reply #(
		.core_type(core_type)
	) u_reply (
		.spi_sck       (spi_sck),
		.bit_cnt       (bit_cnt),
		.byte_cnt      (byte_cnt),
		.cmd           (cmd),
		.ikbd_out      (ikbd_out),
		.ser_out       (ser_out),
		.par_out       (par_out),
		.midi_out      (midi_out),
		.eth_status    (eth_status),
		.eth_tx_byte   (eth_tx_byte),
		.ser_status_out(ser_status_out),
		.miso          (miso)
	);

endmodule

`default_nettype wire

/* tb_spi_master.svh */
`ifndef TB_SPI_MASTER_SVH
`define TB_SPI_MASTER_SVH

// one transaction of command byte and payload with the miso bytes collected in got_q
task automatic send_frame(input logic [7:0] cmd_byte, input logic [7:0] payload[$]);
	logic [7:0] tx[$];
	logic [7:0] rx;
	tx = payload;
	tx.push_front(cmd_byte);
	@(posedge spi_sck);
	SPI_SS_IO <= 1'b0;
	mosi <= tx[0][7];
	for (int b = 0; b < tx.size(); b++) begin
		rx = 8'h00;
		for (int i = 7; i >= 0; i--) begin
			@(posedge spi_sck);
			rx[i] = miso;
			// place the next bit one edge before it is sampled
			if (i > 0) begin
				mosi <= tx[b][i-1];
			end else if (b + 1 < tx.size()) begin
				mosi <= tx[b+1][7];
			end
		end
		exp_q.push_back(expected_reply(cmd_byte, b));
		got_q.push_back(rx);
	end
	// core-side view right after the last byte
	@(negedge spi_sck);
	snap_ikbd = ikbd_in;
	snap_ser = ser_in;
	snap_mac = eth_mac;
	snap_rx = eth_rx;
	@(posedge spi_sck);
	SPI_SS_IO <= 1'b1;
	mosi <= 1'b0;
	repeat (2) @(posedge spi_sck);
endtask

// wait until a strobe has risen target times in total
task automatic wait_rises(input int sel, input int target, input string name);
	int n;
	n = 0;
	while (rise_count(sel) < target && n < 200) begin
		@(negedge spi_sck);
		n++;
	end
	if (rise_count(sel) != target) begin
		$display("%s strobe was seen %0d times, %0d expected", name, rise_count(sel), target);
		errors++;
	end
endtask

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
	if (act !== exp) begin
		$display("Mismatch %s: expected %h, got %h", name, exp, act);
		errors++;
	end
endtask

task automatic check_in(input string name, input io_core_pkg::byte_in_t exp,
		input io_core_pkg::byte_in_t act);
	if (act !== exp) begin
		$display("Mismatch %s: expected %h, got %h", name, exp, act);
		errors++;
	end
endtask

task automatic check_joy(input string name, input io_core_pkg::joy_t exp,
		input io_core_pkg::joy_t act);
	if (act !== exp) begin
		$display("Mismatch %s: expected %h, got %h", name, exp, act);
		errors++;
	end
endtask

task automatic check_ctrl(input string name, input io_core_pkg::ctrl_t exp,
		input io_core_pkg::ctrl_t act);
	if (act !== exp) begin
		$display("Mismatch %s: expected %h, got %h", name, exp, act);
		errors++;
	end
endtask

task automatic check_eth(input string name, input io_core_pkg::eth_stream_t exp,
		input io_core_pkg::eth_stream_t act);
	if (act !== exp) begin
		$display("Mismatch %s: expected %h, got %h", name, exp, act);
		errors++;
	end
endtask

`endif

/* tb_user_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_user_io;

	import io_core_pkg::*;

	// the four read strobes sit from sel_rd_base on in channel order
	localparam int sel_ikbd = 0;
	localparam int sel_ser = 1;
	localparam int sel_rd_base = 2;
	localparam int sel_mac_start = 6;
	localparam int sel_mac = 7;
	localparam int sel_rx_start = 8;
	localparam int sel_rx = 9;
	localparam int sel_tx_begin = 10;
	localparam int sel_tx = 11;
	localparam int num_stb = 12;

	logic spi_sck = 1'b0;
	logic SPI_SS_IO;
	logic mosi;
	logic miso;
	ctrl_t ctrl;
	joy_t joy [4];
	byte_in_t ikbd_in;
	byte_in_t ser_in;
	logic [7:0] ser_status_in;
	eth_stream_t eth_mac;
	eth_stream_t eth_rx;
	byte_out_t ikbd_out;
	byte_out_t ser_out;
	byte_out_t par_out;
	byte_out_t midi_out;
	logic ikbd_rd;
	logic ser_rd;
	logic par_rd;
	logic midi_rd;
	logic [31:0] eth_status;
	logic [7:0] eth_tx_byte;
	logic eth_tx_begin;
	logic eth_tx_strobe;
	logic [63:0] ser_status_out;

	integer seed;
	int errors = 0;
	int chk_idx = 0;
	logic [7:0] exp_q[$];
	logic [7:0] got_q[$];
	byte_in_t snap_ikbd;
	byte_in_t snap_ser;
	eth_stream_t snap_mac;
	eth_stream_t snap_rx;

	// strobe monitor state
	int rises [num_stb];
	logic [num_stb-1:0] prev_stb = '0;
	logic [num_stb-1:0] cur_stb;
	logic [7:0] ikbd_log[$];
	logic [7:0] ser_log[$];
	logic [7:0] mac_log[$];
	logic [7:0] rx_log[$];

	always #50 spi_sck = ~spi_sck;

	user_io #(
		.core_type(8'hA7),
		.num_joy  (4)
	) dut0 (.*);

	function automatic int rise_count(input int sel);
		return rises[sel];
	endfunction

	// expected miso byte for byte idx of a transaction where idx 0 is the command
	function automatic logic [7:0] expected_reply(input logic [7:0] cmd_byte, input int idx);
		int p;
		byte_out_t ch;
		p = idx - 1;
		if (idx == 0) begin
			return 8'hA7;
		end
		case (cmd_byte)
			8'h03, 8'h05, 8'h06, 8'h08: begin
				ch = (cmd_byte == 8'h03) ? ikbd_out : (cmd_byte == 8'h05) ? ser_out :
					(cmd_byte == 8'h06) ? par_out : midi_out;
				// even byte repeats the available flag in every bit
				return (p % 2 == 1) ? ch.data : {8{ch.avail}};
			end
			8'h0A: return eth_status[31 - 8 * (p % 4) -: 8];
			8'h0B: return eth_tx_byte;
			8'h0D: begin
				if (p == 0) begin
					return 8'hA5;
				end
				return (p <= 8) ? ser_status_out[71 - 8 * p -: 8] : 8'h00;
			end
			default: return 8'h00;
		endcase
	endfunction

	`include "tb_spi_master.svh"

	// compares every returned miso byte against the reference
	always @(negedge spi_sck) begin
		if (chk_idx < got_q.size()) begin
			check_byte("miso", exp_q[chk_idx], got_q[chk_idx]);
			chk_idx++;
		end
	end

	always @(negedge spi_sck) begin
		cur_stb = {eth_tx_strobe, eth_tx_begin, eth_rx.strobe, eth_rx.start, eth_mac.strobe,
			eth_mac.start, midi_rd, par_rd, ser_rd, ikbd_rd, ser_in.strobe, ikbd_in.strobe};
		for (int i = 0; i < num_stb; i++) begin
			if (cur_stb[i] === 1'b1 && prev_stb[i] !== 1'b1) begin
				rises[i]++;
			end
		end
		if (cur_stb[sel_ikbd] && !prev_stb[sel_ikbd]) begin
			ikbd_log.push_back(ikbd_in.data);
		end
		if (cur_stb[sel_ser] && !prev_stb[sel_ser]) begin
			ser_log.push_back(ser_in.data);
		end
		if (cur_stb[sel_mac] && !prev_stb[sel_mac]) begin
			mac_log.push_back(eth_mac.data);
		end
		if (cur_stb[sel_rx] && !prev_stb[sel_rx]) begin
			rx_log.push_back(eth_rx.data);
		end
		prev_stb = cur_stb;
	end

	task automatic randomize_core();
		@(posedge spi_sck);
		ikbd_out <= 9'($random(seed));
		ser_out <= 9'($random(seed));
		par_out <= 9'($random(seed));
		midi_out <= 9'($random(seed));
		eth_status <= $random(seed);
		eth_tx_byte <= 8'($random(seed));
		ser_status_out <= {32'($random(seed)), 32'($random(seed))};
		@(posedge spi_sck);
	endtask

	// write n random bytes to a byte channel and check the strobed data
	task automatic write_channel(input logic [7:0] cmd_byte, input int sel, input int n);
		logic [7:0] pay[$];
		int base;
		int cnt;
		base = (sel == sel_ikbd) ? ikbd_log.size() : ser_log.size();
		cnt = rises[sel];
		for (int i = 0; i < n; i++) begin
			pay.push_back(8'($random(seed)));
		end
		send_frame(cmd_byte, pay);
		wait_rises(sel, cnt + n, "byte channel");
		for (int i = 0; i < n; i++) begin
			if (sel == sel_ikbd) begin
				check_byte("ikbd_in.data", pay[i], ikbd_log[base + i]);
			end else begin
				check_byte("ser_in.data", pay[i], ser_log[base + i]);
			end
		end
		if (sel == sel_ikbd) begin
			check_in("ikbd_in", '{strobe: 1'b1, data: pay[n-1]}, snap_ikbd);
			check_in("ikbd_in", '{strobe: 1'b0, data: pay[n-1]}, ikbd_in);
		end else begin
			check_in("ser_in", '{strobe: 1'b1, data: pay[n-1]}, snap_ser);
			check_in("ser_in", '{strobe: 1'b0, data: pay[n-1]}, ser_in);
		end
	endtask

	initial begin
		logic [7:0] pay[$];
		logic [7:0] jv [4];
		logic [7:0] ctrl_val;
		int rd_before [4];
		int base;
		int cnt;
		int n;
		seed = 66861;
		SPI_SS_IO = 1'b1;
		mosi = 1'b0;
		ikbd_out = '0;
		ser_out = '0;
		par_out = '0;
		midi_out = '0;
		eth_status = '0;
		eth_tx_byte = '0;
		ser_status_out = '0;
		repeat (2) @(posedge spi_sck);

		// buttons, switches and joysticks
		ctrl_val = 8'($random(seed));
		pay = '{ctrl_val};
		send_frame(8'h01, pay);
		check_ctrl("ctrl", ctrl_t'(ctrl_val[4:0]), ctrl);
		for (int j = 0; j < 4; j++) begin
			jv[j] = 8'($random(seed));
			pay = '{jv[j]};
			send_frame(8'h10 + 8'(j), pay);
			// earlier joysticks keep their values
			for (int k = 0; k <= j; k++) begin
				check_joy($sformatf("joy[%0d]", k), joy_t'(jv[k][5:0]), joy[k]);
			end
		end
		// joystick writes leave the buttons alone
		check_ctrl("ctrl", ctrl_t'(ctrl_val[4:0]), ctrl);

		write_channel(8'h02, sel_ikbd, 3);
		write_channel(8'h04, sel_ser, 2);

		// polled read channels with two pairs each
		pay = '{8'h00, 8'h00, 8'h00, 8'h00};
		for (int c = 0; c < 4; c++) begin
			randomize_core();
			for (int k = 0; k < 4; k++) begin
				rd_before[k] = rises[sel_rd_base + k];
			end
			send_frame((c == 0) ? 8'h03 : (c == 1) ? 8'h05 : (c == 2) ? 8'h06 : 8'h08, pay);
			wait_rises(sel_rd_base + c, rd_before[c] + 2, "read");
			for (int k = 0; k < 4; k++) begin
				if (k != c && rises[sel_rd_base + k] != rd_before[k]) begin
					$display("read strobe of channel %0d pulsed during a read of channel %0d",
						k, c);
					errors++;
				end
			end
		end

		// ethernet status and serial status
		randomize_core();
		send_frame(8'h0A, pay);
		pay = '{8'h00, 8'($random(seed)), 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
		send_frame(8'h0D, pay);
		check_byte("ser_status_in", pay[1], ser_status_in);

		// mac address bytes
		pay = {};
		for (int i = 0; i < 6; i++) begin
			pay.push_back(8'($random(seed)));
		end
		base = mac_log.size();
		cnt = rises[sel_mac];
		n = rises[sel_mac_start];
		send_frame(8'h09, pay);
		wait_rises(sel_mac_start, n + 1, "mac begin");
		wait_rises(sel_mac, cnt + 6, "mac");
		for (int i = 0; i < 6; i++) begin
			check_byte("eth_mac.data", pay[i], mac_log[base + i]);
		end
		check_eth("eth_mac", '{start: 1'b0, strobe: 1'b1, data: pay[5]}, snap_mac);

		// ethernet receive bytes
		pay = '{8'($random(seed)), 8'($random(seed)), 8'($random(seed))};
		base = rx_log.size();
		cnt = rises[sel_rx];
		n = rises[sel_rx_start];
		send_frame(8'h0C, pay);
		wait_rises(sel_rx_start, n + 1, "rx begin");
		wait_rises(sel_rx, cnt + 3, "rx");
		for (int i = 0; i < 3; i++) begin
			check_byte("eth_rx.data", pay[i], rx_log[base + i]);
		end
		check_eth("eth_rx", '{start: 1'b1, strobe: 1'b1, data: pay[2]}, snap_rx);

		// transmit buffer read with a strobe after the opcode and after each byte
		randomize_core();
		pay = '{8'h00, 8'h00};
		cnt = rises[sel_tx];
		n = rises[sel_tx_begin];
		send_frame(8'h0B, pay);
		wait_rises(sel_tx_begin, n + 1, "tx begin");
		wait_rises(sel_tx, cnt + 3, "tx");

		n = 0;
		while (chk_idx < got_q.size() && n < 100) begin
			@(posedge spi_sck);
			n++;
		end
		if (chk_idx < got_q.size()) begin
			$display("reply checker did not finish all bytes");
			errors++;
		end

		$display("miso bytes checked: %0d, errors: %0d", chk_idx, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#5_000_000;
		$display("simulation timed out");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
io_proto_pkg.sv
io_core_pkg.sv
spi_frame.sv
user_io_cmd.sv
user_io_reply.sv
user_io.sv
tb_user_io.sv

/* Makefile */
# Verilator build and run for the user_io testbench

VERILATOR ?= verilator
TOP ?= tb_user_io
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
